//--- logic/dekatronPkg.sv
`default_nettype none

package dekatronPkg;

    localparam int DigitWidth = 4;   // One BCD digit per tube
    localparam int IpDigits = 3;     // Application digit plus two counting digits
    localparam int LoopDigits = 2;
    localparam int InsnWidth = 4;

    localparam int IpWidth = IpDigits * DigitWidth;
    localparam int IpCountWidth = (IpDigits - 1) * DigitWidth;
    localparam int LoopWidth = LoopDigits * DigitWidth;

    localparam logic [DigitWidth-1:0] DigitMax = DigitWidth'(9);

    // Only the bracket opcodes are decoded on the IP line
    localparam logic [InsnWidth-1:0] OpLoopOpen = InsnWidth'(6);
    localparam logic [InsnWidth-1:0] OpLoopClose = InsnWidth'(7);

    localparam int StepCycles = 3;   // Glow transfer time of one counter step
    localparam int RomLatency = 2;
    localparam int RomDepth = 1000;

    localparam int StepTimerWidth = $clog2(StepCycles + 1);
    localparam int RomTimerWidth = $clog2(RomLatency + 1);
    localparam int RomIndexWidth = $clog2(RomDepth);

    localparam logic [StepTimerWidth-1:0] StepTimerLoad = StepTimerWidth'(StepCycles);
    localparam logic [RomTimerWidth-1:0] RomTimerLoad = RomTimerWidth'(RomLatency);
    localparam logic [RomIndexWidth-1:0] DecimalBase = RomIndexWidth'(10);

endpackage

`default_nettype wire

//--- logic/dekatronCounter.sv
`default_nettype none

module dekatronCounter #(
    parameter int DigitCount = 2
) (
    input  wire Clk,
    input  wire Rst_n,
    input  wire Request,
    input  wire Dec,
    output logic Ready,
    output logic Zero,
    output logic [DigitCount*dekatronPkg::DigitWidth-1:0] Out
);

    logic [dekatronPkg::StepTimerWidth-1:0] stepTimer;
    logic stepDown;

    // One decimal step with carry or borrow rippling up through the digits
    function automatic logic [DigitCount*dekatronPkg::DigitWidth-1:0] stepDigits(
        input logic [DigitCount*dekatronPkg::DigitWidth-1:0] value,
        input logic down
    );
        logic [DigitCount*dekatronPkg::DigitWidth-1:0] result;
        logic [dekatronPkg::DigitWidth-1:0] digit;
        logic carry;
        result = value;
        carry = 1'b1;
        for (int i = 0; i < DigitCount; i++) begin
            digit = value[i*dekatronPkg::DigitWidth +: dekatronPkg::DigitWidth];
            if (carry) begin
                if (down) begin
                    carry = (digit == '0);
                    digit = carry ? dekatronPkg::DigitMax : digit - 1'b1;
                end else begin
                    carry = (digit == dekatronPkg::DigitMax);
                    digit = carry ? '0 : digit + 1'b1;
                end
            end
            result[i*dekatronPkg::DigitWidth +: dekatronPkg::DigitWidth] = digit;
        end
        return result;
    endfunction

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            stepTimer <= '0;
            stepDown <= 1'b0;
            Out <= '0;
        end else if (Request && Ready) begin
            stepTimer <= dekatronPkg::StepTimerLoad;
            stepDown <= Dec;
        end else if (stepTimer != '0) begin
            stepTimer <= stepTimer - 1'b1;
            // Glow settles on the new cathode at the end of the step
            if (stepTimer == 1'b1) begin
                Out <= stepDigits(Out, stepDown);
            end
        end
    end

    assign Ready = (stepTimer == '0);
    assign Zero = (Out == '0);

endmodule

`default_nettype wire

//--- logic/programRom.sv
`default_nettype none

module programRom (
    input  wire Clk,
    input  wire Rst_n,
    input  wire RomRequest,
    input  wire [dekatronPkg::IpWidth-1:0] Address,
    input  wire RomLoad,
    input  wire [dekatronPkg::IpWidth-1:0] RomLoadAddr,
    input  wire [dekatronPkg::InsnWidth-1:0] RomLoadData,
    output logic RomReady,
    output logic [dekatronPkg::InsnWidth-1:0] RomData
);

    logic [dekatronPkg::InsnWidth-1:0] mem [dekatronPkg::RomDepth];
    logic [dekatronPkg::RomTimerWidth-1:0] latency;

    // BCD digits to linear word index with the most significant digit first
    function automatic logic [dekatronPkg::RomIndexWidth-1:0] bcdToIndex(
        input logic [dekatronPkg::IpWidth-1:0] bcd
    );
        logic [dekatronPkg::RomIndexWidth-1:0] index;
        logic [dekatronPkg::RomIndexWidth-1:0] digitValue;
        index = '0;
        for (int i = dekatronPkg::IpDigits - 1; i >= 0; i--) begin
            digitValue = '0;
            digitValue[dekatronPkg::DigitWidth-1:0] =
                bcd[i*dekatronPkg::DigitWidth +: dekatronPkg::DigitWidth];
            index = index * dekatronPkg::DecimalBase + digitValue;
        end
        return index;
    endfunction

    always_ff @(posedge Clk) begin
        if (RomLoad) begin
            mem[bcdToIndex(RomLoadAddr)] <= RomLoadData;
        end
        if (!RomRequest && latency == 1'b1) begin
            RomData <= mem[bcdToIndex(Address)];   // Word lands with RomReady
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            latency <= '0;
            RomReady <= 1'b0;
        end else if (RomRequest) begin
            latency <= dekatronPkg::RomTimerLoad;
            RomReady <= 1'b0;
        end else if (latency != '0) begin
            latency <= latency - 1'b1;
            RomReady <= (latency == 1'b1);
        end
    end

endmodule

`default_nettype wire

//--- logic/ipLine.sv
`default_nettype none

module ipLine (
    input  wire Clk,
    input  wire Rst_n,
    input  wire HaltRq,
    input  wire DataZero,
    input  wire NextApp,
    input  wire Request,
    output logic Ready,
    output logic [dekatronPkg::IpWidth-1:0] IpAddress,
    output logic [dekatronPkg::LoopWidth-1:0] LoopCount,
    output logic RomRequest,
    input  wire RomReady,
    input  wire [dekatronPkg::InsnWidth-1:0] RomData,
    output logic [dekatronPkg::InsnWidth-1:0] Insn
);

    typedef enum logic [2:0] {
        StIdle,
        StIpCount,
        StRomRead,
        StLoopCount,
        StReady,
        StHalt
    } ipStateT;

    ipStateT state;

    logic ipRequest;
    logic ipDec;
    logic ipReady;
    logic [dekatronPkg::IpCountWidth-1:0] ipCount;

    logic loopRequest;
    logic loopDec;
    logic loopReady;
    logic loopZero;

    logic scanBack;   // Direction of the running bracket search
    logic [dekatronPkg::DigitWidth-1:0] appDigit;
    logic keyPrev;

    logic insnOpen;
    logic insnClose;
    logic romOpen;
    logic romClose;
    logic jumpFwd;
    logic jumpBack;

    assign insnOpen = (Insn == dekatronPkg::OpLoopOpen);
    assign insnClose = (Insn == dekatronPkg::OpLoopClose);
    assign romOpen = (RomData == dekatronPkg::OpLoopOpen);
    assign romClose = (RomData == dekatronPkg::OpLoopClose);

    assign jumpFwd = insnOpen && DataZero;     // Skip the loop body
    assign jumpBack = insnClose && !DataZero;  // Repeat the loop body

    assign Ready = !Request && (state == StIdle);
    assign IpAddress = {appDigit, ipCount};

    dekatronCounter #(
        .DigitCount(dekatronPkg::IpDigits - 1)
    ) u_ipCounter (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .Request(ipRequest),
        .Dec(ipDec),
        .Ready(ipReady),
        .Zero(),
        .Out(ipCount)
    );

    dekatronCounter #(
        .DigitCount(dekatronPkg::LoopDigits)
    ) u_loopCounter (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .Request(loopRequest),
        .Dec(loopDec),
        .Ready(loopReady),
        .Zero(loopZero),
        .Out(LoopCount)
    );

    // Application digit advances once per key press
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            appDigit <= '0;
            keyPrev <= 1'b0;
        end else begin
            keyPrev <= NextApp;
            if (NextApp && !keyPrev) begin
                appDigit <= (appDigit == dekatronPkg::DigitMax) ? '0 : appDigit + 1'b1;
            end
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state <= StIdle;
            Insn <= '0;
            ipRequest <= 1'b0;
            ipDec <= 1'b0;
            loopRequest <= 1'b0;
            loopDec <= 1'b0;
            RomRequest <= 1'b0;
            scanBack <= 1'b0;
        end else begin
            ipRequest <= 1'b0;
            loopRequest <= 1'b0;
            RomRequest <= 1'b0;
            case (state)
                StIdle: begin
                    if (HaltRq) begin
                        state <= StHalt;
                    end else if (Request) begin
                        scanBack <= jumpBack;
                        if (!RomReady) begin
                            // Nothing fetched since reset so the current IP is read as is
                            RomRequest <= 1'b1;
                            state <= StRomRead;
                        end else if (jumpFwd || jumpBack) begin
                            loopDec <= 1'b0;   // Depth one for the starting bracket
                            loopRequest <= 1'b1;
                            state <= StLoopCount;
                        end else begin
                            ipDec <= 1'b0;
                            ipRequest <= 1'b1;
                            state <= StIpCount;
                        end
                    end
                end
                StIpCount: begin
                    if (!ipRequest && ipReady) begin
                        RomRequest <= 1'b1;
                        state <= StRomRead;
                    end
                end
                StRomRead: begin
                    if (!RomRequest && RomReady) begin
                        if (loopZero) begin
                            state <= StReady;
                        end else if (romOpen || romClose) begin
                            // Same-kind bracket nests deeper and the other kind unwinds
                            loopDec <= scanBack ? romOpen : romClose;
                            loopRequest <= 1'b1;
                            state <= StLoopCount;
                        end else begin
                            ipDec <= scanBack;
                            ipRequest <= 1'b1;
                            state <= StIpCount;
                        end
                    end
                end
                StLoopCount: begin
                    if (!loopRequest && loopReady) begin
                        if (loopZero) begin
                            state <= StReady;   // Sitting on the matching bracket
                        end else begin
                            ipDec <= scanBack;
                            ipRequest <= 1'b1;
                            state <= StIpCount;
                        end
                    end
                end
                StReady: begin
                    Insn <= RomData;
                    if (!Request) begin
                        state <= StIdle;
                    end
                end
                StHalt: begin
                    if (!HaltRq) begin
                        state <= StIdle;
                    end
                end
                default: state <= StIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/ipSubsystem.sv
`default_nettype none

module ipSubsystem (
    input  wire Clk,
    input  wire Rst_n,
    input  wire Request,
    input  wire DataZero,
    input  wire HaltRq,
    input  wire NextApp,
    input  wire RomLoad,
    input  wire [dekatronPkg::IpWidth-1:0] RomLoadAddr,
    input  wire [dekatronPkg::InsnWidth-1:0] RomLoadData,
    output wire Ready,
    output wire [dekatronPkg::IpWidth-1:0] IpAddress,
    output wire [dekatronPkg::LoopWidth-1:0] LoopCount,
    output wire [dekatronPkg::InsnWidth-1:0] Insn
);

    wire romRequest;
    wire romReady;
    wire [dekatronPkg::InsnWidth-1:0] romData;

    ipLine u_ipLine (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .HaltRq(HaltRq),
        .DataZero(DataZero),
        .NextApp(NextApp),
        .Request(Request),
        .Ready(Ready),
        .IpAddress(IpAddress),
        .LoopCount(LoopCount),
        .RomRequest(romRequest),
        .RomReady(romReady),
        .RomData(romData),
        .Insn(Insn)
    );

    programRom u_rom (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .RomRequest(romRequest),
        .Address(IpAddress),   // ROM follows the live IP
        .RomLoad(RomLoad),
        .RomLoadAddr(RomLoadAddr),
        .RomLoadData(RomLoadData),
        .RomReady(romReady),
        .RomData(romData)
    );

endmodule

`default_nettype wire

//--- testbench/ipLine_chk.sv
`default_nettype none

module ipLine_chk (
    input wire Clk,
    input wire Rst_n,
    input wire Ready,
    input wire RomRequest,
    input wire [dekatronPkg::LoopWidth-1:0] LoopCount,
    input wire [dekatronPkg::InsnWidth-1:0] Insn
);

    // ROM read strobe is a single-cycle pulse
    assert property (@(posedge Clk) disable iff (!Rst_n) RomRequest |=> !RomRequest)
        else $error("RomRequest held for two cycles");

    // Bracket search has unwound fully whenever the line is idle
    assert property (@(posedge Clk) disable iff (!Rst_n) Ready |-> (LoopCount == '0))
        else $error("LoopCount not zero while Ready is high");

    for (genvar d = 0; d < dekatronPkg::LoopDigits; d++) begin : gLoopDigit
        assert property (@(posedge Clk) disable iff (!Rst_n)
            LoopCount[d*dekatronPkg::DigitWidth +: dekatronPkg::DigitWidth]
                <= dekatronPkg::DigitMax)
            else $error("LoopCount digit %0d is not decimal", d);
    end

    assert property (@(posedge Clk) disable iff (!Rst_n) Ready && $past(Ready) |-> $stable(Insn))
        else $error("Insn changed while Ready is high");

endmodule

bind ipLine ipLine_chk u_chk (
    .Clk(Clk),
    .Rst_n(Rst_n),
    .Ready(Ready),
    .RomRequest(RomRequest),
    .LoopCount(LoopCount),
    .Insn(Insn)
);

`default_nettype wire

//--- testbench/ipLineTb.sv
`default_nettype none

module ipLineTb;

    typedef logic [dekatronPkg::IpWidth-1:0] addrT;
    typedef logic [dekatronPkg::InsnWidth-1:0] insnT;
    typedef logic [dekatronPkg::DigitWidth-1:0] digitT;

    logic Clk = 1'b0;
    logic Rst_n;
    logic Request;
    logic DataZero;
    logic HaltRq;
    logic NextApp;
    logic RomLoad;
    addrT RomLoadAddr;
    insnT RomLoadData;
    wire Ready;
    wire [dekatronPkg::IpWidth-1:0] IpAddress;
    wire [dekatronPkg::LoopWidth-1:0] LoopCount;
    wire [dekatronPkg::InsnWidth-1:0] Insn;

    logic [7:0] recKind [$];
    int recA [$];
    int recB [$];
    int recC [$];
    int fetchRecords = 0;
    bit traceLoaded = 1'b0;
    int watchdogCycles = 0;
    int scanLimit = 100;   // Every position of the two counting digits
    int stepCost = 2 * dekatronPkg::StepCycles + dekatronPkg::RomLatency + 6;

    insnT image [dekatronPkg::RomDepth];
    int modelApp;
    int modelIp;
    insnT modelInsn;
    bit modelFresh;

    logic [31:0] lcgState = 32'd18;
    int testCount = 0;
    int failCount = 0;
    int errorCount = 0;
    int fetchNo = 0;

    ipSubsystem u_dut (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .Request(Request),
        .DataZero(DataZero),
        .HaltRq(HaltRq),
        .NextApp(NextApp),
        .RomLoad(RomLoad),
        .RomLoadAddr(RomLoadAddr),
        .RomLoadData(RomLoadData),
        .Ready(Ready),
        .IpAddress(IpAddress),
        .LoopCount(LoopCount),
        .Insn(Insn)
    );

    always #4 Clk = ~Clk;

    function automatic int nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]);
    endfunction

    function automatic int addrToIndex(input addrT a);
        return int'(a[11:8]) * 100 + int'(a[7:4]) * 10 + int'(a[3:0]);
    endfunction

    function automatic addrT modelAddress();
        return {digitT'(modelApp), digitT'(modelIp / 10), digitT'(modelIp % 10)};
    endfunction

    // Reference fetch moves by the previous instruction and then reads the new word
    function automatic void stepModel(input bit dz);
        int depth;
        int dir;
        insnT word;
        if (modelFresh) begin
            modelFresh = 1'b0;
        end else if ((modelInsn == dekatronPkg::OpLoopOpen && dz) ||
                     (modelInsn == dekatronPkg::OpLoopClose && !dz)) begin
            dir = (modelInsn == dekatronPkg::OpLoopOpen) ? 1 : 99;   // 99 is one step back
            depth = 1;
            for (int n = 0; n < scanLimit && depth != 0; n++) begin
                modelIp = (modelIp + dir) % 100;
                word = image[modelApp * 100 + modelIp];
                if (word == modelInsn) begin
                    depth++;
                end else if (word == dekatronPkg::OpLoopOpen ||
                             word == dekatronPkg::OpLoopClose) begin
                    depth--;
                end
            end
        end else begin
            modelIp = (modelIp + 1) % 100;
        end
        modelInsn = image[modelApp * 100 + modelIp];
    endfunction

    task automatic checkValue(input string name, input addrT got, input addrT expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string label, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: pass", label);
        end else begin
            failCount++;
            $display("%s: fail", label);
        end
    endtask

    task automatic readTrace();
        int fd;
        int ch;
        int n;
        int need;
        int a;
        int b;
        int d;
        fd = $fopen("testbench/ipLineTrace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/ipLineTrace.txt");
            errorCount++;
            return;
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while (ch != -1 && ch != "\n") begin
                    ch = $fgetc(fd);
                end
            end else if (ch == "R" || ch == "L" || ch == "F" || ch == "K" || ch == "H") begin
                a = 0;
                b = 0;
                d = 0;
                n = 0;
                need = (ch == "F") ? 3 : (ch == "L" || ch == "K") ? 2 : (ch == "H") ? 1 : 0;
                case (ch)
                    "L", "K": n = $fscanf(fd, "%h %h", a, b);
                    "F": n = $fscanf(fd, "%h %h %h", a, b, d);
                    "H": n = $fscanf(fd, "%h", a);
                    default: n = 0;
                endcase
                if (n != need) begin
                    $display("Trace record %0d of kind %c is incomplete", recKind.size(), ch);
                    errorCount++;
                end
                if (ch == "F") begin
                    fetchRecords++;
                end
                recKind.push_back(ch[7:0]);
                recA.push_back(a);
                recB.push_back(b);
                recC.push_back(d);
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        watchdogCycles = fetchRecords * scanLimit * stepCost + recKind.size() * 64 + 100;
        traceLoaded = 1'b1;
    endtask

    task automatic waitIdle(output int waited);
        waited = 0;
        do begin
            @(negedge Clk);
            waited++;
        end while (!Ready && waited < scanLimit * stepCost + 20);
        if (!Ready) begin
            $display("Ready did not rise within %0d cycles", waited);
            errorCount++;
        end
    endtask

    task automatic applyReset();
        int errorsBefore;
        errorsBefore = errorCount;
        @(negedge Clk);
        Rst_n = 1'b0;
        repeat (2) @(negedge Clk);
        Rst_n = 1'b1;
        modelApp = 0;
        modelIp = 0;
        modelInsn = '0;
        modelFresh = 1'b1;   // First fetch keeps the IP
        @(negedge Clk);
        checkValue("IpAddress", IpAddress, '0);
        checkValue("LoopCount", addrT'(LoopCount), '0);
        checkValue("Insn", addrT'(Insn), '0);
        if (!Ready) begin
            $display("Ready is low after reset");
            errorCount++;
        end
        finishTest("reset", errorsBefore);
    endtask

    task automatic loadWord(input int a, input int d);
        @(negedge Clk);
        RomLoad = 1'b1;
        RomLoadAddr = addrT'(a);
        RomLoadData = insnT'(d);
        image[addrToIndex(addrT'(a))] = insnT'(d);
        @(negedge Clk);
        RomLoad = 1'b0;
    endtask

    task automatic runFetch(input int dz, input int expIp, input int expInsn);
        int errorsBefore;
        int gap;
        int waited;
        addrT modelAddr;
        errorsBefore = errorCount;
        fetchNo++;
        gap = 1 + nextRand() % 5;   // Idle gap before the request
        repeat (gap) @(negedge Clk);
        DataZero = (dz != 0);
        Request = 1'b1;
        @(negedge Clk);
        Request = 1'b0;
        waitIdle(waited);
        stepModel(dz != 0);
        modelAddr = modelAddress();
        if (modelAddr != addrT'(expIp) || modelInsn != insnT'(expInsn)) begin
            $display("[ERROR] trace: IpAddress 0x%h Insn 0x%h, model: IpAddress 0x%h Insn 0x%h",
                     addrT'(expIp), insnT'(expInsn), modelAddr, modelInsn);
            errorCount++;
        end
        checkValue("IpAddress", IpAddress, modelAddr);
        checkValue("Insn", addrT'(Insn), addrT'(modelInsn));
        checkValue("LoopCount", addrT'(LoopCount), '0);
        finishTest($sformatf("fetch %0d at %h in %0d cycles", fetchNo, modelAddr, waited),
                   errorsBefore);
    endtask

    task automatic pressKey(input int presses, input int expIp);
        int errorsBefore;
        errorsBefore = errorCount;
        for (int p = 0; p < presses; p++) begin
            @(negedge Clk);
            NextApp = 1'b1;
            repeat (4) @(negedge Clk);   // Key held over several clocks
            NextApp = 1'b0;
            repeat (2) @(negedge Clk);
        end
        modelApp = (modelApp + presses) % 10;
        if (modelAddress() != addrT'(expIp)) begin
            $display("[ERROR] trace: IpAddress 0x%h, model: IpAddress 0x%h",
                     addrT'(expIp), modelAddress());
            errorCount++;
        end
        checkValue("IpAddress", IpAddress, modelAddress());
        finishTest($sformatf("%0d key presses to application %0d", presses, modelApp),
                   errorsBefore);
    endtask

    task automatic holdHalt(input int cycles);
        int errorsBefore;
        int readyCycles;
        int waited;
        errorsBefore = errorCount;
        readyCycles = 0;
        @(negedge Clk);
        HaltRq = 1'b1;
        for (int c = 0; c < cycles; c++) begin
            @(negedge Clk);
            if (Ready) begin
                readyCycles++;
            end
        end
        HaltRq = 1'b0;
        if (readyCycles != 0) begin
            $display("Ready was high in %0d cycles while halted", readyCycles);
            errorCount++;
        end
        waitIdle(waited);
        finishTest($sformatf("halt for %0d cycles", cycles), errorsBefore);
    endtask

    initial begin
        wait (traceLoaded);
        #(watchdogCycles * 8);
        $display("Watchdog expired after %0d cycles", watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        Rst_n = 1'b0;
        Request = 1'b0;
        DataZero = 1'b0;
        HaltRq = 1'b0;
        NextApp = 1'b0;
        RomLoad = 1'b0;
        RomLoadAddr = '0;
        RomLoadData = '0;
        readTrace();
        for (int r = 0; r < recKind.size(); r++) begin
            case (recKind[r])
                "R": applyReset();
                "L": loadWord(recA[r], recB[r]);
                "F": runFetch(recA[r], recB[r], recC[r]);
                "K": pressKey(recA[r], recB[r]);
                "H": holdHalt(recA[r]);
                default: errorCount++;
            endcase
        end
        if (fetchRecords == 0) begin
            $display("The trace holds no fetch records");
            errorCount++;
        end
        $display("Tests: %0d run, %0d passed, %0d failed, %0d check errors",
                 testCount, testCount - failCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/dekatronPkg.sv
logic/dekatronCounter.sv
logic/programRom.sv
logic/ipLine.sv
logic/ipSubsystem.sv
testbench/ipLine_chk.sv
testbench/ipLineTb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module ipLineTb -Mdir "$OBJ" -o ipLineSim -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/ipLineSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
    echo "No pass message in $LOG"
    exit 1
fi
exit 0

//--- testbench/ipLineTrace.txt
# R reset | L addr data ROM write | F dataZero expIpAddress expInsn fetch
# K presses expIpAddress key presses | H cycles halt held; fields hex, 6 is [ and 7 is ]
R
L 000 6
L 001 6
L 002 2
L 003 7
L 004 7
L 005 3
F 1 000 6
F 1 004 7
F 0 000 6
F 0 001 6
F 0 002 2
F 1 003 7
F 1 004 7
F 1 005 3
# Second image wraps the IP through 99 on a backward jump
R
L 000 7
L 098 6
L 099 1
L 100 5
F 0 000 7
F 0 098 6
F 0 099 1
F 0 000 7
H 6
F 0 098 6
F 0 099 1
K 1 199
F 0 100 5
K 9 000
